//--- nocArbPkg.sv
`default_nettype none

package nocArbPkg;

  // Port order used throughout the router
  //   0 Local
  //   1 North
  //   2 East
  //   3 West
  //   4 South

  // Flit header fields
  localparam int FlitIdWidth = 3;

  // Packet length and width of the hold counter
  localparam int LengthWidth = 12;

  // Flit id code that opens a packet
  localparam logic [FlitIdWidth-1:0] HeadFlitId = FlitIdWidth'(1);

  // Defaults for the arbiter top level
  localparam int DefaultNumPorts  = 5;
  localparam int DefaultFlitWidth = 32;

endpackage

`default_nettype wire

//--- portTimer.sv
`timescale 1ns/1ps
`default_nettype none

module portTimer (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [nocArbPkg::FlitIdWidth-1:0] flitId,
  input  logic [nocArbPkg::LengthWidth-1:0] length,
  input  logic                              runTimer,
  output logic                              timesUp
);

  import nocArbPkg::*;

  // Hold time taken from the most recent head flit
  logic [LengthWidth-1:0] limit;

  // Cycles the port has held the output so far
  logic [LengthWidth-1:0] count;

  // Only head flits carry a valid length
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flitId == HeadFlitId)
    begin
      limit <= length;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (runTimer)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      // Restart as soon as the grant moves away
      count <= '0;
    end
  end

  // Also high at reset while both registers are zero
  assign timesUp = (count == limit);

  // The grant FSM must release the port before the count can run past the limit
  assert property (@(posedge clk) disable iff (rst)
    runTimer |-> count <= limit)
    else $error("portTimer: count %0d passed limit %0d", count, limit);

endmodule

`default_nettype wire

//--- roundRobinGrant.sv
`timescale 1ns/1ps
`default_nettype none

module roundRobinGrant #(
  parameter int NumPorts = nocArbPkg::DefaultNumPorts
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] req,
  input  logic [NumPorts-1:0] timesUp,
  output logic [NumPorts-1:0] grant,
  output logic [NumPorts-1:0] runTimer
);

  logic [NumPorts-1:0] nextGrant;

  // Rotation needs somewhere to go
  if (NumPorts < 2)
  begin : genPortCheck
    $error("roundRobinGrant: NumPorts must be at least 2, got %0d", NumPorts);
  end

  // One-hot state register that is all zero when idle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  always_comb
  begin : nextStateLogic
    int   holder;
    int   idx;
    logic found;
    holder    = 0;
    idx       = 0;
    found     = 1'b0;
    nextGrant = '0;
    runTimer  = '0;

    // Index of the current owner
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
      begin
        holder = i;
      end
    end

    if (grant == '0)
    begin
      // From idle the lowest index requester wins
      for (int i = 0; i < NumPorts; i++)
      begin
        if (req[i] && !found)
        begin
          nextGrant[i] = 1'b1;
          found        = 1'b1;
        end
      end
    end
    else if (req[holder] && !timesUp[holder])
    begin
      // Owner keeps the output and its timer runs
      nextGrant = grant;
      runTimer  = grant;
    end
    else
    begin
      // Rotate starting one past the owner
      // owner is not eligible so a lone requester sees one idle cycle
      for (int off = 1; off < NumPorts; off++)
      begin
        idx = holder + off;
        if (idx >= NumPorts)
        begin
          idx = idx - NumPorts;
        end
        if (req[idx] && !found)
        begin
          nextGrant[idx] = 1'b1;
          found          = 1'b1;
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
    else $error("roundRobinGrant: grant %b is not one-hot", grant);

  assert property (@(posedge clk) disable iff (rst)
    (runTimer & ~grant) == '0)
    else $error("roundRobinGrant: runTimer %b outside grant %b", runTimer, grant);

  // Expired owner must hand the output on at the next edge
  for (genvar k = 0; k < NumPorts; k++)
  begin : genReleaseCheck
    assert property (@(posedge clk) disable iff (rst)
      grant[k] && timesUp[k] |=> !grant[k])
      else $error("roundRobinGrant: port %0d kept the grant after its time was up", k);
  end

endmodule

`default_nettype wire

//--- flitSwitch.sv
`timescale 1ns/1ps
`default_nettype none

module flitSwitch #(
  parameter int NumPorts  = nocArbPkg::DefaultNumPorts,
  parameter int FlitWidth = nocArbPkg::DefaultFlitWidth
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [NumPorts-1:0]                grant,
  input  logic [NumPorts-1:0][FlitWidth-1:0] flit,
  output logic [FlitWidth-1:0]               outFlit,
  output logic                               outValid
);

  logic [FlitWidth-1:0] selFlit;

  // AND-OR select that relies on a one-hot grant
  always_comb
  begin
    selFlit = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      selFlit = selFlit | (flit[i] & {FlitWidth{grant[i]}});
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= |grant;
    end
  end

  // Last flit stays on the output while nobody owns it
  always_ff @(posedge clk)
  begin
    if (|grant)
    begin
      outFlit <= selFlit;
    end
  end

  // Two granted ports would OR their flits together
  assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
    else $error("flitSwitch: grant %b selects more than one port", grant);

endmodule

`default_nettype wire

//--- nocOutputArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module nocOutputArbiter #(
  parameter int NumPorts  = nocArbPkg::DefaultNumPorts,
  parameter int FlitWidth = nocArbPkg::DefaultFlitWidth
) (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic [NumPorts-1:0]                             req,
  input  logic [NumPorts-1:0][nocArbPkg::FlitIdWidth-1:0] flitId,
  input  logic [NumPorts-1:0][nocArbPkg::LengthWidth-1:0] length,
  input  logic [NumPorts-1:0][FlitWidth-1:0]              flit,
  output logic [NumPorts-1:0]                             grant,
  output logic [FlitWidth-1:0]                            outFlit,
  output logic                                            outValid
);

  logic [NumPorts-1:0] timesUp;
  logic [NumPorts-1:0] runTimer;

  // One hold timer per input
  for (genvar i = 0; i < NumPorts; i++)
  begin : genTimer
    portTimer uTimer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (flitId[i]),
      .length   (length[i]),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  // Requests and timer results decide the owner
  roundRobinGrant #(
    .NumPorts (NumPorts)
  ) uGrant (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .timesUp  (timesUp),
    .grant    (grant),
    .runTimer (runTimer)
  );

  // Owner's flit goes to the output one register later
  flitSwitch #(
    .NumPorts  (NumPorts),
    .FlitWidth (FlitWidth)
  ) uSwitch (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .flit     (flit),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

endmodule

`default_nettype wire

//--- tbNocOutputArbiterTasks.svh
`ifndef TB_NOC_OUTPUT_ARBITER_TASKS_SVH
`define TB_NOC_OUTPUT_ARBITER_TASKS_SVH

task automatic checkValue(
  input string       name,
  input logic [63:0] actual,
  input logic [63:0] expected
);
  if (actual !== expected)
  begin
    errorCount++;
    $display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first mismatch");
  end
endtask

function automatic logic [NumPorts-1:0] portBit(input int port);
  portBit       = '0;
  portBit[port] = 1'b1;
endfunction

function automatic int ownerOf(input logic [NumPorts-1:0] grantVec);
  ownerOf = 0;
  for (int i = 0; i < NumPorts; i++)
    if (grantVec[i])
      ownerOf = i;
endfunction

// Hold while requesting and not expired, else rotate past the owner
function automatic logic [NumPorts-1:0] predictGrant(
  input logic [NumPorts-1:0] current,
  input logic [NumPorts-1:0] reqVec,
  input logic [NumPorts-1:0] expired
);
  int owner;
  predictGrant = '0;
  owner        = ownerOf(current);
  if (current == '0)
  begin
    // Scanned downwards so the lowest requester is written last
    for (int i = NumPorts - 1; i >= 0; i--)
      if (reqVec[i])
        predictGrant = portBit(i);
  end
  else if (reqVec[owner] && !expired[owner])
    predictGrant = current;
  else
  begin
    // Nearest requester after the skipped owner
    for (int off = NumPorts - 1; off >= 1; off--)
      if (reqVec[(owner + off) % NumPorts])
        predictGrant = portBit((owner + off) % NumPorts);
  end
endfunction

// New random flits on every port at each falling edge
task automatic nextCycle();
  @(negedge clk);
  for (int i = 0; i < NumPorts; i++)
    flit[i] = $random(seed);
endtask

task automatic startPacket(input int port, input logic [LengthWidth-1:0] len);
  flitId[port] = HeadFlitId;
  length[port] = len;
  req[port]    = 1'b1;
endtask

task automatic endHead(input int port);
  flitId[port] = BodyFlitId;
endtask

task automatic settleIdle();
  req = '0;
  for (int i = 0; i < NumPorts; i++)
    flitId[i] = BodyFlitId;
  nextCycle();
  checkValue("grant", grant, '0);
endtask

task automatic expectGrantRun(input logic [NumPorts-1:0] expected, input int cycles);
  repeat (cycles)
  begin
    nextCycle();
    checkValue("grant", grant, expected);
  end
endtask

task automatic resetStateTest();
  repeat (2)
  begin
    nextCycle();
    checkValue("grant", grant, '0);
    checkValue("outValid", outValid, 1'b0);
  end
endtask

// Lone requester holds for L+1 cycles, then one idle cycle
task automatic singlePortHoldTest();
  int holdLen;
  holdLen = 5;
  settleIdle();
  startPacket(PortEast, LengthWidth'(holdLen));
  expectGrantRun(portBit(PortEast), 1);
  endHead(PortEast);
  expectGrantRun(portBit(PortEast), holdLen);
  expectGrantRun('0, 1);
  expectGrantRun(portBit(PortEast), 1);
endtask

task automatic rotationTest();
  settleIdle();
  for (int p = 0; p < NumPorts; p++)
    startPacket(p, LengthWidth'(3));
  for (int p = 0; p < NumPorts; p++)
    expectGrantRun(portBit(p), 4);
  expectGrantRun(portBit(PortLocal), 4);

  // West owns the output and East is the only other requester
  settleIdle();
  startPacket(PortWest, LengthWidth'(3));
  flitId[PortEast] = HeadFlitId;
  length[PortEast] = LengthWidth'(3);
  expectGrantRun(portBit(PortWest), 1);
  req[PortEast] = 1'b1;
  expectGrantRun(portBit(PortWest), 3);
  expectGrantRun(portBit(PortEast), 4);
  expectGrantRun(portBit(PortWest), 4);
endtask

task automatic earlyReleaseTest();
  settleIdle();
  startPacket(PortNorth, LengthWidth'(10));
  startPacket(PortWest, LengthWidth'(10));
  expectGrantRun(portBit(PortNorth), 3);
  req[PortNorth] = 1'b0;
  expectGrantRun(portBit(PortWest), 2);
  req[PortWest] = 1'b0;
  expectGrantRun('0, 1);
endtask

task automatic flitForwardTest();
  logic [NumPorts-1:0]                prevGrant;
  logic [NumPorts-1:0][FlitWidth-1:0] prevFlit;
  settleIdle();
  startPacket(PortLocal, LengthWidth'(2));
  startPacket(PortEast, LengthWidth'(2));
  prevGrant = modelGrant;
  prevFlit  = flit;
  repeat (20)
  begin
    nextCycle();
    checkValue("outValid", outValid, |prevGrant);
    if (|prevGrant)
      checkValue("outFlit", outFlit, prevFlit[ownerOf(prevGrant)]);
    // Predicted grant now pairs with the flits just driven
    prevGrant = modelGrant;
    prevFlit  = flit;
  end
endtask

task automatic headLengthTest();
  settleIdle();
  startPacket(PortSouth, LengthWidth'(4));
  expectGrantRun(portBit(PortSouth), 1);
  endHead(PortSouth);
  length[PortSouth] = LengthWidth'(9);
  expectGrantRun(portBit(PortSouth), 4);
  expectGrantRun('0, 1);
  expectGrantRun(portBit(PortSouth), 5);
  expectGrantRun('0, 1);
  startPacket(PortSouth, LengthWidth'(2));
  expectGrantRun(portBit(PortSouth), 1);
  endHead(PortSouth);
  expectGrantRun(portBit(PortSouth), 2);
  expectGrantRun('0, 1);
endtask

`endif

//--- tbNocOutputArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module tbNocOutputArbiter;

  import nocArbPkg::*;

  localparam int NumPorts    = 5;
  localparam int FlitWidth   = 32;
  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 10;

  // Reset, its release, then each directed test in run order
  localparam int TestCycles = ResetCycles + 1 + 2 + 9 + 38 + 7 + 21 + 17;

  localparam int PortLocal = 0;
  localparam int PortNorth = 1;
  localparam int PortEast  = 2;
  localparam int PortWest  = 3;
  localparam int PortSouth = 4;

  localparam logic [FlitIdWidth-1:0] BodyFlitId = FlitIdWidth'(2);

  logic                                  clk;
  logic                                  rst;
  logic [NumPorts-1:0]                   req;
  logic [NumPorts-1:0][FlitIdWidth-1:0]  flitId;
  logic [NumPorts-1:0][LengthWidth-1:0]  length;
  logic [NumPorts-1:0][FlitWidth-1:0]    flit;
  logic [NumPorts-1:0]                   grant;
  logic [FlitWidth-1:0]                  outFlit;
  logic                                  outValid;

  integer seed       = 32'h2916_cec4;
  int     errorCount = 0;

  // Reference model state
  logic [NumPorts-1:0]    modelGrant;
  logic                   modelValid;
  logic [LengthWidth-1:0] modelLimit [NumPorts];
  logic [LengthWidth-1:0] modelCount [NumPorts];

  `include "tbNocOutputArbiterTasks.svh"

  nocOutputArbiter #(
    .NumPorts  (NumPorts),
    .FlitWidth (FlitWidth)
  ) u_dut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitId   (flitId),
    .length   (length),
    .flit     (flit),
    .grant    (grant),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Hold time bookkeeping and grant prediction on each rising edge
  always @(posedge clk)
  begin : referenceModel
    logic [NumPorts-1:0] expired;
    for (int i = 0; i < NumPorts; i++)
      expired[i] = (modelCount[i] == modelLimit[i]);
    if (rst)
    begin
      modelGrant <= '0;
      modelValid <= 1'b0;
      for (int i = 0; i < NumPorts; i++)
      begin
        modelLimit[i] <= '0;
        modelCount[i] <= '0;
      end
    end
    else
    begin
      modelGrant <= predictGrant(modelGrant, req, expired);
      modelValid <= |modelGrant;
      for (int i = 0; i < NumPorts; i++)
      begin
        if (flitId[i] == HeadFlitId)
          modelLimit[i] <= length[i];
        if (modelGrant[i] && req[i] && !expired[i])
          modelCount[i] <= modelCount[i] + 1'b1;
        else
          modelCount[i] <= '0;
      end
    end
  end

  // Registered outputs are stable at the falling edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      checkValue("grant", grant, modelGrant);
      checkValue("outValid", outValid, modelValid);
    end
  end

  initial
  begin : watchdog
    #(TestCycles * 2 * ClkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", TestCycles * 2);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial
  begin : testSequence
    rst    = 1'b1;
    req    = '0;
    flitId = '0;
    length = '0;
    for (int i = 0; i < NumPorts; i++)
      flit[i] = $random(seed);
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    resetStateTest();
    singlePortHoldTest();
    rotationTest();
    earlyReleaseTest();
    flitForwardTest();
    headLengthTest();

    if (errorCount == 0)
    begin
      $display("NO ERRORS");
    end
    else
    begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- nocOutputArbiter.f
+incdir+.
nocArbPkg.sv
portTimer.sv
roundRobinGrant.sv
flitSwitch.sv
nocOutputArbiter.sv
tbNocOutputArbiter.sv

//--- Bender.yml
package:
  name: nocOutputArbiter

sources:
  # Package first, then the RTL from leaves to the top level
  - files:
      - nocArbPkg.sv
      - portTimer.sv
      - roundRobinGrant.sv
      - flitSwitch.sv
      - nocOutputArbiter.sv

  # Testbench top, which includes tbNocOutputArbiterTasks.svh
  - target: test
    include_dirs:
      - .
    files:
      - tbNocOutputArbiter.sv
